/* common/perceptron_pkg.sv */
`default_nettype none

package perceptron_pkg;

  localparam int n_features = 4;
  localparam int feature_width = 8;
  localparam int word_width = 16;

  typedef logic signed [feature_width-1:0] feature_t;
  typedef logic signed [word_width-1:0] word_t;
  typedef word_t delta_t;

  typedef struct packed {
    feature_t value;
    logic last;
    logic train;
    logic target;
  } feature_beat_t;

  // value[0] holds the first beat of the sample
  typedef struct packed {
    feature_t [n_features-1:0] value;
    logic train;
    logic target;
  } sample_t;

  typedef struct packed {
    word_t sum;
    logic train;
    logic target;
  } argument_t;

  typedef struct packed {
    logic [7:0] activation;
    logic train;
    logic target;
  } activation_t;

  typedef struct packed {
    logic [7:0] activation;
    logic signed [1:0] error;
  } prediction_t;

endpackage

`default_nettype wire

/* perceptron.f */
common/perceptron_pkg.sv
source/sample_loader.sv
perceptron/weighted_sum.sv
perceptron/threshold.sv
source/error_unit.sv
source/perceptron_top.sv
sim/perceptron_checker.sv
sim/perceptron_tb.sv

/* perceptron/threshold.sv */
`timescale 1ns/1ps
`default_nettype none

module threshold (
  input  logic clock,
  input  logic reset,

  input  logic argument_valid,
  input  perceptron_pkg::argument_t argument,
  output logic argument_ready,

  output logic result_valid,
  output perceptron_pkg::activation_t result,
  input  logic result_ready,

  input  logic error_valid,
  input  perceptron_pkg::delta_t error,
  output logic error_ready,

  output logic propagate_valid,
  output perceptron_pkg::delta_t propagate,
  input  logic propagate_ready
);
  import perceptron_pkg::*;

  typedef enum logic [1:0] {s_argument, s_result, s_error, s_propagate} state_t;

  state_t state;
  argument_t held;

  assign argument_ready = state == s_argument;
  assign error_ready = state == s_error;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_argument;
    end else begin
      case (state)
        s_argument: begin
          if (argument_valid) begin
            state <= s_result;
          end
        end
        s_result: begin
          if (result_valid && result_ready) begin
            // only training samples wait for an error
            if (held.train) begin
              state <= s_error;
            end else begin
              state <= s_argument;
            end
          end
        end
        s_error: begin
          if (error_valid) begin
            state <= s_propagate;
          end
        end
        s_propagate: begin
          if (propagate_valid && propagate_ready) begin
            state <= s_argument;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (argument_valid && argument_ready) begin
      held <= argument;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (state == s_result) begin
      if (!result_valid) begin
        result_valid <= 1'b1;
      end else if (result_ready) begin
        result_valid <= 1'b0;
      end
    end
  end

  // sign rule, zero counts as positive
  always_ff @(posedge clock) begin
    if (state == s_result && !result_valid) begin
      result.activation <= (held.sum >= 0) ? 8'hff : 8'h00;
      result.train <= held.train;
      result.target <= held.target;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      propagate_valid <= 1'b0;
    end else if (error_valid && error_ready) begin
      propagate_valid <= 1'b1;
    end else if (propagate_valid && propagate_ready) begin
      propagate_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (error_valid && error_ready) begin
      propagate <= error;
    end
  end

endmodule

`default_nettype wire

/* perceptron/weighted_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module weighted_sum #(
  parameter int n_features = perceptron_pkg::n_features
) (
  input  logic clock,
  input  logic reset,

  input  logic sample_valid,
  input  perceptron_pkg::sample_t sample,
  output logic sample_ready,

  output logic argument_valid,
  output perceptron_pkg::argument_t argument,
  input  logic argument_ready,

  input  logic propagate_valid,
  input  perceptron_pkg::delta_t propagate,
  output logic propagate_ready
);
  import perceptron_pkg::*;

  localparam int acc_width = 32;
  localparam int idx_width = (n_features > 1) ? $clog2(n_features) : 1;
  localparam logic signed [acc_width-1:0] word_max = 2 ** (word_width - 1) - 1;
  localparam logic signed [acc_width-1:0] word_min = -(2 ** (word_width - 1));

  typedef enum logic [1:0] {s_idle, s_mac, s_out, s_update} state_t;

  state_t state;
  sample_t held;
  word_t weights [n_features];
  word_t bias;
  word_t next_weights [n_features];
  word_t next_bias;
  logic signed [acc_width-1:0] acc;
  logic signed [acc_width-1:0] mac_sum;
  logic [idx_width-1:0] idx;

  function automatic word_t saturate(input logic signed [acc_width-1:0] value);
    if (value > word_max) begin
      return word_t'(word_max);
    end else if (value < word_min) begin
      return word_t'(word_min);
    end
    return word_t'(value);
  endfunction

  assign sample_ready = state == s_idle;
  assign propagate_ready = state == s_update;

  always_comb begin
    logic signed [acc_width-1:0] grown;
    feature_t x;
    x = held.value[idx];
    mac_sum = acc + weights[idx] * x;
    // learning rule: w += delta * x, bias += delta
    for (int i = 0; i < n_features; i++) begin
      x = held.value[i];
      grown = weights[i] + propagate * x;
      next_weights[i] = saturate(grown);
    end
    grown = bias + propagate;
    next_bias = saturate(grown);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
      argument_valid <= 1'b0;
      idx <= '0;
      bias <= '0;
      for (int i = 0; i < n_features; i++) begin
        weights[i] <= '0;
      end
    end else begin
      case (state)
        s_idle: begin
          if (sample_valid) begin
            idx <= '0;
            state <= s_mac;
          end
        end
        s_mac: begin
          idx <= idx + 1'b1;
          if (idx == idx_width'(n_features - 1)) begin
            argument_valid <= 1'b1;
            state <= s_out;
          end
        end
        s_out: begin
          if (argument_ready) begin
            argument_valid <= 1'b0;
            if (held.train) begin
              state <= s_update;
            end else begin
              state <= s_idle;
            end
          end
        end
        s_update: begin
          if (propagate_valid) begin
            weights <= next_weights;
            bias <= next_bias;
            state <= s_idle;
          end
        end
      endcase
    end
  end

  // accumulator starts at the bias, last step writes the saturated sum
  always_ff @(posedge clock) begin
    if (sample_valid && sample_ready) begin
      held <= sample;
      acc <= bias;
    end else if (state == s_mac) begin
      acc <= mac_sum;
      argument <= '{sum: saturate(mac_sum), train: held.train, target: held.target};
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the perceptron testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
pass_text="Finished with no errors"

verilator --binary --timing -Wno-fatal \
  --top-module perceptron_tb \
  -f perceptron.f \
  -Mdir "$build_dir" \
  -o perceptron_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$build_dir/perceptron_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^${pass_text}\$" "$log_file"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* sim/perceptron_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module perceptron_checker (
  input  logic clock,
  input  logic reset,
  input  logic feature_ready,
  input  logic prediction_valid,
  input  perceptron_pkg::prediction_t prediction,
  input  logic prediction_ready,
  input  logic expect_valid,
  input  perceptron_pkg::prediction_t expect_value,
  input  logic done,
  input  int run_errors,
  output int error_count,
  output int checked_count
);
  import perceptron_pkg::*;

  prediction_t expected [$];
  prediction_t want;
  prediction_t stalled_value;
  logic stalled;
  logic in_reset;
  logic reported;

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] want_value);
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, want_value);
    error_count++;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      in_reset = 1'b1;
      stalled = 1'b0;
      reported = 1'b0;
      error_count = 0;
      checked_count = 0;
      expected.delete();
    end else begin
      // first cycle out of reset
      if (in_reset) begin
        in_reset = 1'b0;
        if (prediction_valid !== 1'b0) begin
          report_mismatch("prediction_valid", 16'(prediction_valid), 16'h0);
        end
        if (feature_ready !== 1'b1) begin
          report_mismatch("feature_ready", 16'(feature_ready), 16'h1);
        end
      end

      if (expect_valid) begin
        expected.push_back(expect_value);
      end

      // a stalled prediction must stay put
      if (stalled) begin
        if (prediction_valid !== 1'b1) begin
          report_mismatch("prediction_valid", 16'(prediction_valid), 16'h1);
        end else if (prediction !== stalled_value) begin
          report_mismatch("prediction", 16'(prediction), 16'(stalled_value));
        end
      end
      stalled = prediction_valid && !prediction_ready;
      stalled_value = prediction;

      if (prediction_valid && prediction_ready) begin
        if (expected.size() == 0) begin
          $display("prediction at %0t arrived with no sample outstanding", $time);
          error_count++;
        end else begin
          want = expected.pop_front();
          checked_count++;
          if (prediction.activation !== want.activation) begin
            report_mismatch("prediction.activation", 16'(prediction.activation),
                            16'(want.activation));
          end
          if (prediction.error !== want.error) begin
            report_mismatch("prediction.error", 16'(prediction.error), 16'(want.error));
          end
        end
      end

      if (done && !reported) begin
        reported = 1'b1;
        if (expected.size() != 0) begin
          $display("%0d expected predictions never arrived", expected.size());
          error_count += expected.size();
        end
        $display("checked %0d predictions: %0d check errors, %0d run errors",
                 checked_count, error_count, run_errors);
      end
    end
  end

endmodule

`default_nettype wire

/* sim/perceptron_stim.txt */
// train target f0 f1 f2 f3 activation error, one hex byte each
// expected columns follow the learning rule starting from zero weights
01 00 0a 14 05 fd ff ff
00 01 0a 14 05 fd 00 00
01 01 1e 04 02 01 00 01
00 00 1e 04 02 01 ff 00
01 01 05 f6 00 07 ff 00
01 00 f8 0c 06 02 00 00
01 00 0f 0a ec 09 ff ff
00 00 0f 0a ec 09 00 00
00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 01
00 00 00 00 00 00 ff 00
01 01 80 7f 80 7f 00 01
00 00 80 7f 80 7f ff 00
01 00 64 9c 32 ce 00 00
01 01 64 9c 32 ce 00 01
00 01 64 9c 32 ce 00 00
00 00 01 02 03 04 ff 00
01 00 01 02 03 04 ff ff
00 00 01 02 03 04 ff 00
01 00 ff fe fd fc 00 00

/* sim/perceptron_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module perceptron_tb;
  import perceptron_pkg::*;

  localparam int max_samples = 32;
  // train, target, four features, activation, error
  localparam int fields = 8;
  localparam int wait_limit = 500;

  logic clock;
  logic reset;
  logic feature_valid;
  feature_beat_t feature;
  logic feature_ready;
  logic prediction_valid;
  prediction_t prediction;
  logic prediction_ready;

  logic expect_valid;
  prediction_t expect_value;
  logic done;
  int run_errors;
  int error_count;
  int checked_count;
  int n_samples;
  int seed;
  logic ready_draw;
  logic [15:0] stim [max_samples * fields];

  perceptron_top #(
    .n_features(n_features)
  ) dut (
    .clock(clock),
    .reset(reset),
    .feature_valid(feature_valid),
    .feature(feature),
    .feature_ready(feature_ready),
    .prediction_valid(prediction_valid),
    .prediction(prediction),
    .prediction_ready(prediction_ready)
  );

  perceptron_checker monitor (
    .clock(clock),
    .reset(reset),
    .feature_ready(feature_ready),
    .prediction_valid(prediction_valid),
    .prediction(prediction),
    .prediction_ready(prediction_ready),
    .expect_valid(expect_valid),
    .expect_value(expect_value),
    .done(done),
    .run_errors(run_errors),
    .error_count(error_count),
    .checked_count(checked_count)
  );

  always #5 clock = ~clock;

  // random back-pressure on the result
  // drawn on the edge, ahead of the gap draws one step later
  always @(posedge clock) begin
    ready_draw = $unsigned($random(seed)) % 4 != 0;
    #1;
    prediction_ready = ready_draw;
  end

  task automatic load_stimulus;
    for (int a = 0; a < max_samples * fields; a++) begin
      stim[a] = 16'hf000 | 16'(a);
    end
    $readmemh("sim/perceptron_stim.txt", stim);
    n_samples = 0;
    while (n_samples < max_samples && stim[n_samples * fields] <= 16'h0001) begin
      n_samples++;
    end
    if (n_samples == 0) begin
      $display("no samples found in sim/perceptron_stim.txt");
      run_errors++;
    end
  endtask

  task automatic send_sample(input int s);
    int base;
    int gap;
    int waited;
    logic accepted;
    base = s * fields;
    expect_value.activation = stim[base + 6][7:0];
    expect_value.error = stim[base + 7][1:0];
    expect_valid = 1'b1;
    @(posedge clock);
    #1;
    expect_valid = 1'b0;
    accepted = 1'b1;
    for (int b = 0; b < n_features && accepted; b++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clock);
        #1;
      end
      feature_valid = 1'b1;
      feature.value = stim[base + 2 + b][7:0];
      feature.last = b == n_features - 1;
      feature.train = stim[base][0];
      feature.target = stim[base + 1][0];
      accepted = 1'b0;
      waited = 0;
      while (!accepted && waited < wait_limit) begin
        accepted = feature_ready;
        @(posedge clock);
        #1;
        waited++;
      end
      feature_valid = 1'b0;
      if (!accepted) begin
        $display("feature beat %0d of sample %0d was never accepted", b, s);
        run_errors++;
      end
    end
  endtask

  task automatic wait_for_predictions;
    int waited;
    waited = 0;
    while (checked_count < n_samples && waited < wait_limit) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (checked_count < n_samples) begin
      $display("only %0d of %0d predictions arrived in time", checked_count, n_samples);
      run_errors++;
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    feature_valid = 1'b0;
    feature = '0;
    prediction_ready = 1'b0;
    expect_valid = 1'b0;
    expect_value = '0;
    done = 1'b0;
    run_errors = 0;
    seed = 32'hd0c1;
    load_stimulus();
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int s = 0; s < n_samples && run_errors == 0; s++) begin
      send_sample(s);
    end
    if (run_errors == 0) begin
      wait_for_predictions();
    end
    done = 1'b1;
    @(posedge clock);
    #1;
    if (error_count == 0 && run_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/error_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module error_unit (
  input  logic clock,
  input  logic reset,

  input  logic result_valid,
  input  perceptron_pkg::activation_t result,
  output logic result_ready,

  output logic prediction_valid,
  output perceptron_pkg::prediction_t prediction,
  input  logic prediction_ready,

  output logic error_valid,
  output perceptron_pkg::delta_t error,
  input  logic error_ready
);
  import perceptron_pkg::*;

  logic training;
  logic signed [1:0] error_value;

  // one sample in flight until its error has gone back
  assign result_ready = !prediction_valid && !error_valid;

  always_comb begin
    if (result.target && result.activation == 8'h00) begin
      error_value = 2'sd1;
    end else if (!result.target && result.activation == 8'hff) begin
      error_value = -2'sd1;
    end else begin
      error_value = 2'sd0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      prediction_valid <= 1'b0;
      error_valid <= 1'b0;
    end else if (result_valid && result_ready) begin
      prediction_valid <= 1'b1;
    end else if (prediction_valid && prediction_ready) begin
      prediction_valid <= 1'b0;
      error_valid <= training;
    end else if (error_valid && error_ready) begin
      error_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (result_valid && result_ready) begin
      prediction.activation <= result.activation;
      prediction.error <= result.train ? error_value : 2'sd0;
      training <= result.train;
    end
  end

  // prediction holds until the next result, so the delta can come from it
  assign error = delta_t'($signed(prediction.error));

endmodule

`default_nettype wire

/* source/perceptron_top.sv */
`timescale 1ns/1ps
`default_nettype none

module perceptron_top #(
  parameter int n_features = perceptron_pkg::n_features
) (
  input  logic clock,
  input  logic reset,

  input  logic feature_valid,
  input  perceptron_pkg::feature_beat_t feature,
  output logic feature_ready,

  output logic prediction_valid,
  output perceptron_pkg::prediction_t prediction,
  input  logic prediction_ready
);
  import perceptron_pkg::*;

  logic sample_valid;
  logic sample_ready;
  sample_t sample;

  logic argument_valid;
  logic argument_ready;
  argument_t argument;

  logic result_valid;
  logic result_ready;
  activation_t result;

  logic error_valid;
  logic error_ready;
  delta_t error;

  logic propagate_valid;
  logic propagate_ready;
  delta_t propagate;

  sample_loader loader (
    .clock(clock),
    .reset(reset),
    .feature_valid(feature_valid),
    .feature(feature),
    .feature_ready(feature_ready),
    .sample_valid(sample_valid),
    .sample(sample),
    .sample_ready(sample_ready)
  );

  weighted_sum #(
    .n_features(n_features)
  ) sum (
    .clock(clock),
    .reset(reset),
    .sample_valid(sample_valid),
    .sample(sample),
    .sample_ready(sample_ready),
    .argument_valid(argument_valid),
    .argument(argument),
    .argument_ready(argument_ready),
    .propagate_valid(propagate_valid),
    .propagate(propagate),
    .propagate_ready(propagate_ready)
  );

  threshold activation (
    .clock(clock),
    .reset(reset),
    .argument_valid(argument_valid),
    .argument(argument),
    .argument_ready(argument_ready),
    .result_valid(result_valid),
    .result(result),
    .result_ready(result_ready),
    .error_valid(error_valid),
    .error(error),
    .error_ready(error_ready),
    .propagate_valid(propagate_valid),
    .propagate(propagate),
    .propagate_ready(propagate_ready)
  );

  error_unit output_side (
    .clock(clock),
    .reset(reset),
    .result_valid(result_valid),
    .result(result),
    .result_ready(result_ready),
    .prediction_valid(prediction_valid),
    .prediction(prediction),
    .prediction_ready(prediction_ready),
    .error_valid(error_valid),
    .error(error),
    .error_ready(error_ready)
  );

endmodule

`default_nettype wire

/* source/sample_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_loader (
  input  logic clock,
  input  logic reset,

  input  logic feature_valid,
  input  perceptron_pkg::feature_beat_t feature,
  output logic feature_ready,

  output logic sample_valid,
  output perceptron_pkg::sample_t sample,
  input  logic sample_ready
);
  import perceptron_pkg::*;

  logic take_beat;

  // no new beats while a full sample waits
  assign feature_ready = !sample_valid;
  assign take_beat = feature_valid && feature_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else if (take_beat && feature.last) begin
      sample_valid <= 1'b1;
    end else if (sample_valid && sample_ready) begin
      sample_valid <= 1'b0;
    end
  end

  // shift in from the top so the first beat lands in value[0]
  always_ff @(posedge clock) begin
    if (take_beat) begin
      sample.value <= {feature.value, sample.value[n_features-1:1]};
      if (feature.last) begin
        sample.train <= feature.train;
        sample.target <= feature.target;
      end
    end
  end

endmodule

`default_nettype wire
